/* hdl/cache_pkg.sv */
// cache subsystem package
// address fields, burst timing, shared vector types and FSM encodings

package cache_pkg;

  // byte address |tag|line|col|00|
  localparam int addr_bits = 12;
  localparam int zero_bits = 2;
  localparam int col_bits = 3;
  localparam int line_bits = 4;
  localparam int tag_bits = addr_bits - line_bits - col_bits - zero_bits;
  // backing memory is addressed in 64-bit beats
  localparam int beat_addr_bits = 9;

  // burst command spacing and read turnaround, in clock cycles
  localparam int cmd_interval = 13;
  localparam int read_latency = 6;

  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [3:0] byte_en_t;
  typedef logic [line_bits-1:0] line_ix_t;
  typedef logic [col_bits-1:0] col_ix_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [beat_addr_bits-1:0] beat_addr_t;
  typedef logic [addr_bits-1:0] bus_addr_t;

  typedef enum logic [3:0] {
    cache_idle,
    cache_read_wait,
    cache_read1,
    cache_read2,
    cache_read3,
    cache_read_tag,
    cache_read_finish,
    cache_write1,
    cache_write2,
    cache_write3,
    cache_write_finish
  } cache_state_e;

  typedef enum logic [1:0] {
    ram_idle,
    ram_latency,
    ram_read_burst,
    ram_write_burst
  } ram_state_e;

  typedef enum logic [1:0] {
    front_idle,
    front_settle,
    front_access,
    front_done
  } front_state_e;

endpackage

/* hdl/cache_ifs.sv */
// cache request and burst memory interfaces
// request held by the bus front end, bursts between cache and backing RAM
`timescale 1ns/1ns

interface cache_req_if;
  import cache_pkg::*;

  logic enable;
  bus_addr_t address;
  word_t data_in;
  // nonzero only for writes
  byte_en_t write_enable;
  word_t data_out;
  logic data_out_ready;
  logic busy;

  modport front (
    output enable, address, data_in, write_enable,
    input data_out, data_out_ready, busy
  );

  modport cache (
    input enable, address, data_in, write_enable,
    output data_out, data_out_ready, busy
  );
endinterface

interface burst_if;
  import cache_pkg::*;

  // 1 write, 0 read
  logic cmd;
  logic cmd_en;
  beat_addr_t addr;
  beat_t wr_data;
  beat_t rd_data;
  logic rd_data_valid;

  modport master (
    output cmd, cmd_en, addr, wr_data,
    input rd_data, rd_data_valid
  );

  modport slave (
    input cmd, cmd_en, addr, wr_data,
    output rd_data, rd_data_valid
  );
endinterface

/* hdl/bram.sv */
// byte-enabled single-port block RAM
// read is registered and returns the word held before a same-cycle write
`timescale 1ns/1ns

module bram #(
  parameter int addr_bits = 4
) (
  input logic clk,
  input cache_pkg::byte_en_t write_enable,
  input logic [addr_bits-1:0] address,
  input cache_pkg::word_t data_in,
  output cache_pkg::word_t data_out
);
  import cache_pkg::*;

  word_t mem [2 ** addr_bits];

  always_ff @(posedge clk) begin
    for (int b = 0; b < $bits(byte_en_t); b++) begin
      if (write_enable[b]) begin
        mem[address][8 * b +: 8] <= data_in[8 * b +: 8];
      end
    end
    data_out <= mem[address];
  end

endmodule

/* hdl/wb_front.sv */
// Wishbone classic slave front end
// captures one bus cycle, holds it toward the cache and acks it once
`timescale 1ns/1ns

module wb_front (
  input logic clk,
  input logic rst_n,
  input logic cyc,
  input logic stb,
  input logic we,
  input cache_pkg::bus_addr_t adr,
  input cache_pkg::word_t dat_w,
  input cache_pkg::byte_en_t sel,
  output cache_pkg::word_t dat_r,
  output logic ack,
  cache_req_if.front req
);
  import cache_pkg::*;

  front_state_e state;
  logic finish;

  // reads end on ready data, writes once the cache stops stalling
  assign finish = (req.write_enable != '0) ? !req.busy : req.data_out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= front_idle;
      req.enable <= 1'b0;
      ack <= 1'b0;
    end else begin
      case (state)
        front_idle: begin
          if (cyc && stb) begin
            state <= front_settle;
          end
        end
        // address is on the RAMs now, outputs are valid next cycle
        front_settle: begin
          req.enable <= 1'b1;
          state <= front_access;
        end
        front_access: begin
          if (finish) begin
            req.enable <= 1'b0;
            ack <= 1'b1;
            state <= front_done;
          end
        end
        // stb may still be high from the acked cycle
        front_done: begin
          ack <= 1'b0;
          state <= front_idle;
        end
        default: state <= front_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == front_idle && cyc && stb) begin
      req.address <= adr;
      req.data_in <= dat_w;
      req.write_enable <= we ? sel : '0;
    end
    if (state == front_access && req.data_out_ready) begin
      dat_r <= req.data_out;
    end
  end

endmodule

/* hdl/cache.sv */
// direct-mapped write-back cache, 16 lines of 8 words
// fills lines by four-beat bursts and writes back dirty victims first
`timescale 1ns/1ns

module cache (
  input logic clk,
  input logic rst_n,
  cache_req_if.cache req,
  burst_if.master br
);
  import cache_pkg::*;

  typedef logic [$clog2(cmd_interval + 1) - 1:0] wait_t;

  cache_state_e state;
  wait_t cmd_wait;
  logic sweeping;
  logic sweep_settle;
  logic sweep_active;
  line_ix_t sweep_ix;

  tag_t address_tag;
  line_ix_t line_ix;
  col_ix_t column_ix;
  beat_addr_t fill_addr;
  beat_addr_t victim_addr;

  // tag RAM word holds {dirty, valid, tag}
  line_ix_t tag_addr;
  byte_en_t tag_we;
  word_t tag_d;
  word_t tag_q;
  tag_t cached_tag;
  logic line_valid;
  logic line_dirty;
  logic hit;
  logic hit_write;

  word_t col_q [2 ** col_bits];
  logic fill_write;
  // first column of the beat being filled
  col_ix_t fill_col;

  assign column_ix = req.address[zero_bits +: col_bits];
  assign line_ix = req.address[zero_bits + col_bits +: line_bits];
  assign address_tag = req.address[zero_bits + col_bits + line_bits +: tag_bits];

  assign fill_addr = {address_tag, line_ix, {(col_bits - 1){1'b0}}};
  assign victim_addr = {cached_tag, line_ix, {(col_bits - 1){1'b0}}};

  assign cached_tag = tag_q[tag_bits-1:0];
  assign line_valid = tag_q[tag_bits];
  assign line_dirty = tag_q[tag_bits+1];
  assign hit = line_valid && cached_tag == address_tag;

  assign sweep_active = sweeping || sweep_settle;
  assign req.busy = sweep_active || state != cache_idle || cmd_wait != '0 ||
                    (req.enable && !hit);
  assign req.data_out = col_q[column_ix];
  assign req.data_out_ready = req.enable && hit && req.write_enable == '0 &&
                              state == cache_idle && !sweep_active;
  // busy already covers a miss, so this is a hit write
  assign hit_write = req.enable && !req.busy && req.write_enable != '0;

  always_comb begin
    fill_write = br.rd_data_valid;
    case (state)
      cache_read1: fill_col = col_ix_t'(2);
      cache_read2: fill_col = col_ix_t'(4);
      cache_read3: fill_col = col_ix_t'(6);
      cache_read_wait: fill_col = '0;
      default: begin
        fill_col = '0;
        fill_write = 1'b0;
      end
    endcase
  end

  always_comb begin
    tag_we = '0;
    tag_d = '0;
    if (sweeping) begin
      tag_we = '1;
    end else if (state == cache_read_tag) begin
      tag_we = '1;
      tag_d = word_t'({2'b01, address_tag});
    end else if (hit_write) begin
      tag_we = '1;
      tag_d = word_t'({2'b11, address_tag});
    end
  end

  assign tag_addr = sweeping ? sweep_ix : line_ix;

  bram #(.addr_bits(line_bits)) tag_ram (
    .clk,
    .write_enable(tag_we),
    .address(tag_addr),
    .data_in(tag_d),
    .data_out(tag_q)
  );

  for (genvar i = 0; i < 2 ** col_bits; i++) begin : column
    byte_en_t we;
    word_t d;

    always_comb begin
      we = '0;
      d = req.data_in;
      if (fill_write && fill_col == col_ix_t'(i & ~1)) begin
        we = '1;
        d = br.rd_data[32 * (i % 2) +: 32];
      end else if (hit_write && column_ix == col_ix_t'(i)) begin
        we = req.write_enable;
      end
    end

    bram #(.addr_bits(line_bits)) col_ram (
      .clk,
      .write_enable(we),
      .address(line_ix),
      .data_in(d),
      .data_out(col_q[i])
    );
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= cache_idle;
      cmd_wait <= '0;
      br.cmd_en <= 1'b0;
      sweeping <= 1'b1;
      sweep_settle <= 1'b0;
      sweep_ix <= '0;
    end else begin
      br.cmd_en <= 1'b0;
      if (cmd_wait != '0) begin
        cmd_wait <= cmd_wait - 1'b1;
      end
      // one extra cycle lets the tag output leave the sweep address
      sweep_settle <= sweeping && sweep_ix == '1;
      if (sweeping) begin
        sweep_ix <= sweep_ix + 1'b1;
        if (sweep_ix == '1) begin
          sweeping <= 1'b0;
        end
      end
      case (state)
        cache_idle: begin
          if (req.enable && !hit && cmd_wait == '0 && !sweep_active) begin
            br.cmd_en <= 1'b1;
            cmd_wait <= wait_t'(cmd_interval);
            if (line_dirty) begin
              br.cmd <= 1'b1;
              br.addr <= victim_addr;
              br.wr_data <= {col_q[1], col_q[0]};
              state <= cache_write1;
            end else begin
              br.cmd <= 1'b0;
              br.addr <= fill_addr;
              state <= cache_read_wait;
            end
          end
        end
        cache_read_wait: begin
          if (br.rd_data_valid) begin
            state <= cache_read1;
          end
        end
        cache_read1: state <= cache_read2;
        cache_read2: state <= cache_read3;
        cache_read3: state <= cache_read_tag;
        cache_read_tag: state <= cache_read_finish;
        cache_read_finish: state <= cache_idle;
        cache_write1: begin
          br.wr_data <= {col_q[3], col_q[2]};
          state <= cache_write2;
        end
        cache_write2: begin
          br.wr_data <= {col_q[5], col_q[4]};
          state <= cache_write3;
        end
        cache_write3: begin
          br.wr_data <= {col_q[7], col_q[6]};
          state <= cache_write_finish;
        end
        cache_write_finish: begin
          if (cmd_wait == '0) begin
            br.cmd_en <= 1'b1;
            br.cmd <= 1'b0;
            br.addr <= fill_addr;
            cmd_wait <= wait_t'(cmd_interval);
            state <= cache_read_wait;
          end
        end
        default: state <= cache_idle;
      endcase
    end
  end

endmodule

/* hdl/burst_ram.sv */
// burst RAM model standing in for the external PSRAM
// four-beat 64-bit bursts, reads answer after a fixed latency
`timescale 1ns/1ns

module burst_ram (
  input logic clk,
  input logic rst_n,
  burst_if.slave br
);
  import cache_pkg::*;

  typedef logic [$clog2(read_latency) - 1:0] lat_t;

  beat_t mem [2 ** beat_addr_bits];
  ram_state_e state;
  beat_addr_t base;
  beat_addr_t beat_addr;
  beat_addr_t mem_waddr;
  logic mem_we;
  lat_t lat_cnt;
  logic [col_bits-2:0] beat_cnt;

  assign beat_addr = base + beat_addr_t'(beat_cnt);

  // first write beat comes with the command, before base is latched
  assign mem_we = (state == ram_idle && br.cmd_en && br.cmd) || state == ram_write_burst;
  assign mem_waddr = (state == ram_idle) ? br.addr : beat_addr;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_waddr] <= br.wr_data;
    end
    br.rd_data <= mem[beat_addr];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ram_idle;
      br.rd_data_valid <= 1'b0;
      beat_cnt <= '0;
      lat_cnt <= '0;
    end else begin
      case (state)
        ram_idle: begin
          if (br.cmd_en) begin
            base <= br.addr;
            if (br.cmd) begin
              beat_cnt <= beat_cnt + 1'b1;
              state <= ram_write_burst;
            end else begin
              // two cycles go to the command and the registered read
              lat_cnt <= lat_t'(read_latency - 2);
              state <= ram_latency;
            end
          end
        end
        ram_latency: begin
          if (lat_cnt == '0) begin
            br.rd_data_valid <= 1'b1;
            beat_cnt <= beat_cnt + 1'b1;
            state <= ram_read_burst;
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        ram_read_burst: begin
          // counter wraps to zero while the last beat is out
          if (beat_cnt == '0) begin
            br.rd_data_valid <= 1'b0;
            state <= ram_idle;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        ram_write_burst: begin
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == '1) begin
            state <= ram_idle;
          end
        end
        default: state <= ram_idle;
      endcase
    end
  end

endmodule

/* hdl/cache_top.sv */
// cache subsystem top level with a Wishbone classic slave port
// front end, cache and burst RAM joined by the request and burst interfaces
`timescale 1ns/1ns

module cache_top (
  input logic clk,
  input logic rst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input cache_pkg::bus_addr_t wb_adr,
  input cache_pkg::word_t wb_dat_w,
  input cache_pkg::byte_en_t wb_sel,
  output cache_pkg::word_t wb_dat_r,
  output logic wb_ack
);

  cache_req_if req_if ();
  burst_if br_if ();

  wb_front front_i (
    .clk,
    .rst_n,
    .cyc(wb_cyc),
    .stb(wb_stb),
    .we(wb_we),
    .adr(wb_adr),
    .dat_w(wb_dat_w),
    .sel(wb_sel),
    .dat_r(wb_dat_r),
    .ack(wb_ack),
    .req(req_if.front)
  );

  cache cache_i (
    .clk,
    .rst_n,
    .req(req_if.cache),
    .br(br_if.master)
  );

  burst_ram ram_i (
    .clk,
    .rst_n,
    .br(br_if.slave)
  );

endmodule

/* test/cache_asserts.sv */
// protocol assertions for the Wishbone port and the burst command stream
// bound onto the cache top level
`timescale 1ns/1ns

module cache_asserts (
  input logic clk,
  input logic rst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic cmd_en
);
  import cache_pkg::*;

  int since_cmd;
  int failures = 0;

  // cycles since the last burst command, saturating at the interval
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      since_cmd <= cmd_interval;
    end else if (cmd_en) begin
      since_cmd <= 1;
    end else if (since_cmd < cmd_interval) begin
      since_cmd <= since_cmd + 1;
    end
  end

  ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack stayed high for more than one cycle");
      failures++;
    end

  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> wb_cyc && wb_stb)
    else begin
      $error("wb_ack raised outside a cyc and stb cycle");
      failures++;
    end

  cmd_single: assert property (@(posedge clk) disable iff (!rst_n) cmd_en |=> !cmd_en)
    else begin
      $error("burst cmd_en stayed high for more than one cycle");
      failures++;
    end

  cmd_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_en |-> since_cmd >= cmd_interval)
    else begin
      $error("burst commands closer than the minimum interval");
      failures++;
    end

endmodule

/* test/cache_checker.sv */
// Wishbone checker for the cache subsystem
// keeps a byte shadow of all writes and compares every read acknowledge
`timescale 1ns/1ns

module cache_checker (
  input logic clk,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input cache_pkg::bus_addr_t wb_adr,
  input cache_pkg::word_t wb_dat_w,
  input cache_pkg::byte_en_t wb_sel,
  input cache_pkg::word_t wb_dat_r,
  input logic wb_ack,
  input logic [7:0] test_id,
  input logic check_exp,
  input cache_pkg::word_t exp_data,
  input logic test_end,
  input logic run_end,
  input int timeouts,
  output int errors
);
  import cache_pkg::*;

  logic [7:0] shadow [2 ** addr_bits];
  logic known [2 ** addr_bits];

  // request as seen when it started
  logic in_req = 1'b0;
  logic [7:0] req_id;
  logic req_we;
  bus_addr_t req_adr;
  word_t req_dat;
  byte_en_t req_sel;
  logic req_chk;
  word_t req_exp;

  int requests = 0;
  int acks = 0;
  int checks = 0;
  int test_checks = 0;
  int test_errors = 0;

  initial begin
    errors = 0;
    for (int i = 0; i < 2 ** addr_bits; i++) begin
      known[i] = 1'b0;
    end
  end

  task automatic report_if_differs(input word_t expected, input word_t mask);
    if ((wb_dat_r & mask) !== (expected & mask)) begin
      $display("MISMATCH at %0t: test %0d addr 0x%03h expected 0x%08h got 0x%08h",
               $time, req_id, req_adr, expected & mask, wb_dat_r & mask);
      errors++;
      test_errors++;
    end
  endtask

  task automatic store_write();
    bus_addr_t ix;
    for (int b = 0; b < $bits(byte_en_t); b++) begin
      ix = {req_adr[addr_bits-1:zero_bits], zero_bits'(b)};
      if (req_sel[b]) begin
        shadow[ix] = req_dat[8 * b +: 8];
        known[ix] = 1'b1;
      end
    end
  endtask

  task automatic compare_read();
    word_t expect_w;
    word_t mask;
    bus_addr_t ix;
    expect_w = '0;
    mask = '0;
    for (int b = 0; b < $bits(byte_en_t); b++) begin
      ix = {req_adr[addr_bits-1:zero_bits], zero_bits'(b)};
      if (known[ix]) begin
        expect_w[8 * b +: 8] = shadow[ix];
        mask[8 * b +: 8] = 8'hff;
      end
    end
    checks++;
    test_checks++;
    // table entries carry the whole expected word
    if (req_chk) begin
      report_if_differs(req_exp, '1);
    end
    report_if_differs(expect_w, mask);
  endtask

  always @(posedge clk) begin
    if (wb_ack) begin
      acks++;
      if (!in_req) begin
        $display("acknowledge at %0t with no request pending", $time);
        errors++;
        test_errors++;
      end else if (req_we) begin
        store_write();
      end else begin
        compare_read();
      end
      in_req = 1'b0;
    end else if (wb_cyc && wb_stb && !in_req) begin
      in_req = 1'b1;
      requests++;
      req_id = test_id;
      req_we = wb_we;
      req_adr = wb_adr;
      req_dat = wb_dat_w;
      req_sel = wb_sel;
      req_chk = check_exp;
      req_exp = exp_data;
    end
    if (test_end) begin
      $display("test %0d finished: %0d reads checked, %0d errors",
               test_id, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
    if (run_end) begin
      if (in_req || requests != acks) begin
        $display("%0d requests were made but %0d acknowledges came", requests, acks);
        errors++;
      end
      $display("requests %0d, acks %0d, reads checked %0d, errors %0d, timeouts %0d",
               requests, acks, checks, errors, timeouts);
    end
  end

endmodule

/* test/cache_tb.sv */
// testbench for the cache subsystem
// table of directed accesses, then a seeded random phase over conflicting lines
`timescale 1ns/1ns

module cache_tb;
  import cache_pkg::*;

  localparam int ack_timeout = 200;
  localparam int random_ops = 200;

  typedef struct packed {
    logic [7:0] id;
    logic we;
    bus_addr_t adr;
    word_t data;
    byte_en_t sel;
    logic chk;
    word_t exp;
  } step_t;

  logic clk;
  logic rst_n;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  bus_addr_t wb_adr;
  word_t wb_dat_w;
  byte_en_t wb_sel;
  word_t wb_dat_r;
  logic wb_ack;
  logic [7:0] test_id;
  logic check_exp;
  word_t exp_data;
  logic test_end;
  logic run_end;
  int timeouts;
  int errors;
  step_t steps [$];

  cache_top cache_top_i (
    .clk,
    .rst_n,
    .wb_cyc,
    .wb_stb,
    .wb_we,
    .wb_adr,
    .wb_dat_w,
    .wb_sel,
    .wb_dat_r,
    .wb_ack
  );

  cache_checker checker_i (
    .clk,
    .wb_cyc,
    .wb_stb,
    .wb_we,
    .wb_adr,
    .wb_dat_w,
    .wb_sel,
    .wb_dat_r,
    .wb_ack,
    .test_id,
    .check_exp,
    .exp_data,
    .test_end,
    .run_end,
    .timeouts,
    .errors
  );

  bind cache_top cache_asserts asserts_i (
    .clk,
    .rst_n,
    .wb_cyc,
    .wb_stb,
    .wb_ack,
    .cmd_en(br_if.cmd_en)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic add_step(input logic [7:0] id, input logic we, input bus_addr_t adr,
                          input word_t data, input byte_en_t sel, input logic chk,
                          input word_t exp);
    steps.push_back({id, we, adr, data, sel, chk, exp});
  endtask

  task automatic add_write(input logic [7:0] id, input bus_addr_t adr, input word_t data,
                           input byte_en_t sel);
    add_step(id, 1'b1, adr, data, sel, 1'b0, '0);
  endtask

  task automatic add_read(input logic [7:0] id, input bus_addr_t adr, input word_t exp);
    add_step(id, 1'b0, adr, '0, '1, 1'b1, exp);
  endtask

  // one Wishbone classic transfer, held until ack or timeout
  task automatic access(input step_t s);
    int n;
    @(negedge clk);
    test_id = s.id;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = s.we;
    wb_adr = s.adr;
    wb_dat_w = s.data;
    wb_sel = s.sel;
    check_exp = s.chk;
    exp_data = s.exp;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < ack_timeout);
    if (wb_ack) begin
      // stb stays up through the edge where ack is taken
      @(negedge clk);
    end else begin
      $display("test %0d: no acknowledge came for the access to 0x%03h within %0d cycles",
               s.id, s.adr, ack_timeout);
      timeouts++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    check_exp = 1'b0;
  endtask

  task automatic end_test(input logic [7:0] id);
    @(negedge clk);
    test_id = id;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    logic [7:0] prev_id;
    logic [31:0] r;
    bus_addr_t adr;
    byte_en_t sel;
    void'($urandom(61453));
    rst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = '0;
    test_id = '0;
    check_exp = 1'b0;
    exp_data = '0;
    test_end = 1'b0;
    run_end = 1'b0;
    timeouts = 0;

    // fill on first touch, hit on repeat
    add_write(8'd1, 12'h040, 32'h1234_5678, 4'hf);
    add_read(8'd1, 12'h040, 32'h1234_5678);
    add_write(8'd1, 12'h064, 32'hcafe_f00d, 4'hf);
    add_read(8'd1, 12'h064, 32'hcafe_f00d);
    add_read(8'd1, 12'h064, 32'hcafe_f00d);
    // byte lanes merge into the old word
    add_write(8'd2, 12'h0a0, 32'h1122_3344, 4'hf);
    add_write(8'd2, 12'h0a0, 32'haabb_ccdd, 4'b0101);
    add_write(8'd2, 12'h0a0, 32'h9900_0000, 4'b1000);
    add_read(8'd2, 12'h0a0, 32'h99bb_33dd);
    add_write(8'd2, 12'h0a8, 32'hffff_ffff, 4'hf);
    add_write(8'd2, 12'h0a8, 32'h0000_0000, 4'b0011);
    add_read(8'd2, 12'h0a8, 32'hffff_0000);
    // whole line 6 pushed out by tag 1, then refilled by the reverse reads
    for (int c = 0; c < 8; c++) begin
      add_write(8'd3, bus_addr_t'(12'h0c0 + 4 * c), word_t'(32'h3c00_0000 + c), 4'hf);
    end
    add_write(8'd3, 12'h2c0, 32'h3c11_0000, 4'hf);
    for (int c = 7; c >= 0; c--) begin
      add_read(8'd3, bus_addr_t'(12'h0c0 + 4 * c), word_t'(32'h3c00_0000 + c));
    end
    add_read(8'd3, 12'h2c0, 32'h3c11_0000);
    // line 9 under tags 0, 1 and 2
    add_write(8'd4, 12'h120, 32'ha5a5_0001, 4'hf);
    add_write(8'd4, 12'h124, 32'ha5a5_0002, 4'hf);
    add_write(8'd4, 12'h320, 32'h5a5a_0003, 4'hf);
    add_read(8'd4, 12'h120, 32'ha5a5_0001);
    add_read(8'd4, 12'h124, 32'ha5a5_0002);
    add_read(8'd4, 12'h320, 32'h5a5a_0003);
    add_write(8'd4, 12'h520, 32'h0f0f_0004, 4'hf);
    add_read(8'd4, 12'h520, 32'h0f0f_0004);
    add_read(8'd4, 12'h120, 32'ha5a5_0001);

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // idle bus for a while so the checker can flag any stray ack
    repeat (4) @(negedge clk);

    prev_id = steps[0].id;
    foreach (steps[i]) begin
      if (steps[i].id != prev_id) begin
        end_test(prev_id);
        prev_id = steps[i].id;
      end
      access(steps[i]);
    end
    end_test(prev_id);

    // 64 words over 8 tags, lines 10 and 11 and columns 0 to 3
    for (int i = 0; i < random_ops; i++) begin
      r = $urandom;
      adr = {r[2:0], 3'b101, r[3], 1'b0, r[5:4], 2'b00};
      sel = r[8] ? r[12:9] : 4'hf;
      if (sel == '0) begin
        sel = '1;
      end
      access({8'd5, r[8], adr, word_t'($urandom), sel, 1'b0, 32'h0});
    end
    end_test(8'd5);

    @(negedge clk);
    run_end = 1'b1;
    @(negedge clk);
    run_end = 1'b0;
    if (errors == 0 && timeouts == 0 && cache_top_i.asserts_i.failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
hdl/cache_pkg.sv
hdl/cache_ifs.sv
hdl/bram.sv
hdl/wb_front.sv
hdl/cache.sv
hdl/burst_ram.sv
hdl/cache_top.sv
test/cache_asserts.sv
test/cache_checker.sv
test/cache_tb.sv

/* Makefile */
# Verilator build, run and lint for the cache subsystem testbench

TOP = cache_tb

all: run

run:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 | \
		awk '{ print } /Simulation PASSED/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
